/* morseTypesPkg.sv */
package morseTypesPkg;

    // one-hot command level, highest set bit selects the word
    typedef enum logic [3:0] {
        CMD_NONE = 4'b0000,
        CMD_OOO  = 4'b0001,  // dash dash dash
        CMD_OSO  = 4'b0010,  // dash dot dash
        CMD_SOS  = 4'b0100,  // dot dash dot
        CMD_SSS  = 4'b1000   // dot dot dot
    } morseCmd;

    // symbol request from the word sequencer to the symbol timer
    typedef enum logic [1:0] {
        SYM_NONE = 2'b00,
        SYM_DASH = 2'b01,
        SYM_DOT  = 2'b10
    } symbolKind;

    // sound outputs of the subsystem
    // key is the envelope, buzzer the gated square wave
    typedef struct packed {
        logic key;
        logic buzzer;
    } soundOut;

endpackage

/* morseTimingPkg.sv */
package morseTimingPkg;

    // kept short so a whole word fits in a short simulation
    localparam int UNIT_CYCLES = 4;  // clocks per morse unit

    localparam int DOT_UNITS  = 1;  // key-down length of a dot
    localparam int DASH_UNITS = 3;  // key-down length of a dash
    localparam int GAP_UNITS  = 1;  // key-up after every symbol

    // buzzer half period in clocks
    localparam int TONE_HALF_CYCLES = 2;

endpackage

/* cmdControl.sv */
module cmdControl (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  morseTypesPkg::morseCmd   cmd,
    input  logic                     symDone,
    output morseTypesPkg::symbolKind symReq,
    output logic                     cmdDone
);

    // three symbol steps, then the done strobe and its release
    typedef enum logic [2:0] {
        STEP0,
        STEP1,
        STEP2,
        FINISH,
        RELEASE
    } stepState;

    stepState step;

    /*
     * word table, highest command bit wins
     *   SSS  dot  dot  dot
     *   SOS  dot  dash dot
     *   OSO  dash dot  dash
     *   OOO  dash dash dash
     */
    function automatic morseTypesPkg::symbolKind wordSymbol(
        input logic [3:0] c,
        input stepState   s
    );
        logic middle;
        middle = (s == STEP1);
        if (c[3]) begin
            return morseTypesPkg::SYM_DOT;
        end else if (c[2]) begin
            return middle ? morseTypesPkg::SYM_DASH : morseTypesPkg::SYM_DOT;
        end else if (c[1]) begin
            return middle ? morseTypesPkg::SYM_DOT : morseTypesPkg::SYM_DASH;
        end else begin
            return morseTypesPkg::SYM_DASH;
        end
    endfunction

    // step after a finished symbol
    function automatic stepState nextStep(input stepState s);
        case (s)
            STEP0:   return STEP1;
            STEP1:   return STEP2;
            default: return FINISH;
        endcase
    endfunction

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            step    <= STEP0;
            symReq  <= morseTypesPkg::SYM_NONE;
            cmdDone <= 1'b0;
        end else if (cmd != morseTypesPkg::CMD_NONE) begin  // no command freezes the word
            case (step)
                STEP0, STEP1, STEP2: begin
                    if (symDone) begin
                        // drop the request, next one comes a cycle later
                        symReq <= morseTypesPkg::SYM_NONE;
                        step   <= nextStep(step);
                    end else begin
                        symReq <= wordSymbol(cmd, step);
                    end
                end

                FINISH: begin
                    cmdDone <= 1'b1;
                    step    <= RELEASE;
                end

                RELEASE: begin
                    cmdDone <= 1'b0;
                    step    <= STEP0;  // held command repeats the word
                end

                default: begin
                    step <= STEP0;
                end
            endcase
        end
    end

endmodule

/* symbolTimer.sv */
module symbolTimer (
    input  logic                     CLK,
    input  logic                     RSTn,
    input  morseTypesPkg::symbolKind symReq,
    output logic                     key,
    output logic                     symDone
);

    // wide enough for the longest period, the dash mark
    typedef logic [$clog2(morseTimingPkg::DASH_UNITS * morseTimingPkg::UNIT_CYCLES)-1:0]
        countT;

    typedef enum logic [1:0] {
        IDLE,
        MARK,
        SPACE,
        DONE
    } timerState;

    timerState state;
    countT     remain;  // cycles left in this period minus one

    // last count value for a period of the given number of units
    function automatic countT lastCount(input int units);
        return countT'(units * morseTimingPkg::UNIT_CYCLES - 1);
    endfunction

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            state  <= IDLE;
            remain <= '0;
        end else begin
            case (state)
                IDLE: begin
                    case (symReq)
                        morseTypesPkg::SYM_DOT: begin
                            remain <= lastCount(morseTimingPkg::DOT_UNITS);
                            state  <= MARK;
                        end
                        morseTypesPkg::SYM_DASH: begin
                            remain <= lastCount(morseTimingPkg::DASH_UNITS);
                            state  <= MARK;
                        end
                        default: begin
                            state <= IDLE;
                        end
                    endcase
                end

                MARK: begin
                    if (remain == '0) begin
                        remain <= lastCount(morseTimingPkg::GAP_UNITS);
                        state  <= SPACE;
                    end else begin
                        remain <= remain - 1'b1;
                    end
                end

                SPACE: begin
                    if (remain == '0) begin
                        state <= DONE;
                    end else begin
                        remain <= remain - 1'b1;
                    end
                end

                default: begin
                    state <= IDLE;  // DONE lasts one cycle
                end
            endcase
        end
    end

    assign key     = (state == MARK);
    assign symDone = (state == DONE);

endmodule

/* toneGenerator.sv */
module toneGenerator (
    input  logic CLK,
    input  logic RSTn,
    input  logic key,
    output logic buzzer
);

    typedef logic [$clog2(morseTimingPkg::TONE_HALF_CYCLES + 1)-1:0] halfT;

    halfT halfCnt;  // clocks into the current half period
    logic phase;

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            halfCnt <= '0;
            phase   <= 1'b0;
        end else if (!key) begin
            // every mark starts from the same phase
            halfCnt <= '0;
            phase   <= 1'b0;
        end else if (halfCnt == halfT'(morseTimingPkg::TONE_HALF_CYCLES - 1)) begin
            halfCnt <= '0;
            phase   <= ~phase;
        end else begin
            halfCnt <= halfCnt + 1'b1;
        end
    end

    // phase lags key by a cycle at the end of a mark, so gate it here
    assign buzzer = key & phase;

endmodule

/* morseTop.sv */
module morseTop (
    input  logic                   CLK,
    input  logic                   RSTn,
    input  morseTypesPkg::morseCmd cmd,
    output morseTypesPkg::soundOut snd,
    output logic                   cmdDone
);

    morseTypesPkg::symbolKind symReq;
    logic                     symDone;
    logic                     keyLevel;  // envelope from the timer
    logic                     tone;

    // word sequencer
    cmdControl uCmdControl (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .cmd     (cmd),
        .symDone (symDone),
        .symReq  (symReq),
        .cmdDone (cmdDone)
    );

    // one dot or dash plus its gap
    symbolTimer uSymbolTimer (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .symReq  (symReq),
        .key     (keyLevel),
        .symDone (symDone)
    );

    toneGenerator uToneGenerator (
        .CLK    (CLK),
        .RSTn   (RSTn),
        .key    (keyLevel),
        .buzzer (tone)
    );

    assign snd = '{key: keyLevel, buzzer: tone};

endmodule

/* tbClock.sv */
module tbClock (
    output logic CLK
);

    localparam int HALF_PERIOD = 5;  // period 10

    initial begin
        CLK = 1'b0;
    end

    always #HALF_PERIOD CLK = ~CLK;

endmodule

/* morseTb.sv */
module morseTb;

    localparam int DOT_CYCLES  = morseTimingPkg::DOT_UNITS * morseTimingPkg::UNIT_CYCLES;
    localparam int DASH_CYCLES = morseTimingPkg::DASH_UNITS * morseTimingPkg::UNIT_CYCLES;
    localparam int GAP_CYCLES  = morseTimingPkg::GAP_UNITS * morseTimingPkg::UNIT_CYCLES;
    localparam int WORD_LIMIT  = 100;  // cycles allowed for one word

    typedef struct packed {
        morseTypesPkg::morseCmd   cmd;
        morseTypesPkg::symbolKind sym0;
        morseTypesPkg::symbolKind sym1;
        morseTypesPkg::symbolKind sym2;
        logic [1:0]               repeats;
    } testRow;

    logic                   CLK;
    logic                   RSTn;
    morseTypesPkg::morseCmd cmd;
    morseTypesPkg::soundOut snd;
    logic                   cmdDone;

    testRow                   rows[$];
    string                    names[$];
    morseTypesPkg::symbolKind seen[$];  // marks measured by the monitor
    testRow                   curRow = '0;  // row now being driven
    string                    curName = "reset";
    int                       errCount = 0;
    int                       doneCount = 0;
    bit                       monitorOn = 1'b0;

    tbClock uClock (.CLK(CLK));

    morseTop DUT (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .cmd     (cmd),
        .snd     (snd),
        .cmdDone (cmdDone)
    );

    task automatic addTest(input string name, input morseTypesPkg::morseCmd c,
                           input morseTypesPkg::symbolKind s0, input morseTypesPkg::symbolKind s1,
                           input morseTypesPkg::symbolKind s2, input int rep);
        testRow r;
        r.cmd     = c;
        r.sym0    = s0;
        r.sym1    = s1;
        r.sym2    = s2;
        r.repeats = 2'(rep);
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic reportFault(input string msg);
        $display("ERROR %s: %s", curName, msg);
        errCount++;
    endtask

    task automatic checkSymbol(input string name, input morseTypesPkg::symbolKind expected,
                               input morseTypesPkg::symbolKind actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %s, actual %s", name, expected.name(), actual.name());
            errCount++;
        end
    endtask

    task automatic checkSound(input string name, input morseTypesPkg::soundOut expected,
                              input morseTypesPkg::soundOut actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected snd %b, actual snd %b", name, expected, actual);
            errCount++;
        end
    endtask

    // NONE for a length that is neither dot nor dash
    function automatic morseTypesPkg::symbolKind markKind(input int len);
        if (len == DOT_CYCLES) begin
            return morseTypesPkg::SYM_DOT;
        end else if (len == DASH_CYCLES) begin
            return morseTypesPkg::SYM_DASH;
        end
        return morseTypesPkg::SYM_NONE;
    endfunction

    function automatic morseTypesPkg::symbolKind rowSymbol(input testRow r, input int k);
        case (k)
            0:       return r.sym0;
            1:       return r.sym1;
            default: return r.sym2;
        endcase
    endfunction

    // sees the cycle that just ended
    int   highLen = 0;
    int   lowLen = 0;
    int   wordSyms = 0;
    logic lastDone = 1'b0;

    always @(posedge CLK) begin : monitorBlk
        morseTypesPkg::soundOut   wantSnd;
        morseTypesPkg::symbolKind kind;
        int                       markLen;
        if (monitorOn) begin
            if (snd.key) begin
                if (highLen == 0 && wordSyms > 0 && lowLen < GAP_CYCLES) begin
                    reportFault($sformatf("key-low run of only %0d clocks inside a word", lowLen));
                end
                // length of this mark from the table
                markLen = (rowSymbol(curRow, seen.size() % 3) == morseTypesPkg::SYM_DASH) ?
                          DASH_CYCLES : DOT_CYCLES;
                wantSnd.key    = highLen < markLen;
                wantSnd.buzzer = ((highLen / morseTimingPkg::TONE_HALF_CYCLES) % 2) == 1;
                highLen++;
                lowLen = 0;
            end else begin
                if (highLen > 0) begin
                    kind = markKind(highLen);
                    if (kind == morseTypesPkg::SYM_NONE) begin
                        reportFault($sformatf("bad mark length of %0d clocks", highLen));
                    end
                    seen.push_back(kind);
                    wordSyms++;
                end
                wantSnd = '0;  // silent while key is up
                highLen = 0;
                lowLen++;
            end
            checkSound(curName, wantSnd, snd);

            if (cmdDone) begin
                if (lastDone) begin
                    reportFault("cmdDone high for more than one cycle");
                end else begin
                    doneCount++;
                    if (cmd == morseTypesPkg::CMD_NONE) reportFault("cmdDone with no command");
                    if (wordSyms != 3) reportFault($sformatf("cmdDone after %0d marks", wordSyms));
                    if (snd.key || lowLen < GAP_CYCLES) reportFault("cmdDone before the last gap");
                end
                wordSyms = 0;
            end
            lastDone = cmdDone;
        end
    end

    // at most two words per row
    initial begin : watchdog
        #1;
        #((rows.size() * 2 * 80 + 20) * 10);
        $display("watchdog expired before the test table finished");
        $display("Something failed");
        $finish;
    end

    initial begin : mainSeq
        testRow row;
        int     reps;
        int     waited;
        int     startErr;
        int     passCount;
        int     failCount;
        RSTn      = 1'b0;
        cmd       = morseTypesPkg::CMD_NONE;
        passCount = 0;
        failCount = 0;

        addTest("SSS", morseTypesPkg::CMD_SSS, morseTypesPkg::SYM_DOT, morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DOT, 1);
        addTest("SOS", morseTypesPkg::CMD_SOS, morseTypesPkg::SYM_DOT, morseTypesPkg::SYM_DASH,
                morseTypesPkg::SYM_DOT, 1);
        addTest("OSO", morseTypesPkg::CMD_OSO, morseTypesPkg::SYM_DASH, morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DASH, 1);
        addTest("OOO", morseTypesPkg::CMD_OOO, morseTypesPkg::SYM_DASH, morseTypesPkg::SYM_DASH,
                morseTypesPkg::SYM_DASH, 1);
        addTest("prioSosOoo", morseTypesPkg::morseCmd'(4'b0101), morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DASH, morseTypesPkg::SYM_DOT, 1);
        addTest("prioAll", morseTypesPkg::morseCmd'(4'b1111), morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DOT, morseTypesPkg::SYM_DOT, 1);
        addTest("prioOsoOoo", morseTypesPkg::morseCmd'(4'b0011), morseTypesPkg::SYM_DASH,
                morseTypesPkg::SYM_DOT, morseTypesPkg::SYM_DASH, 1);
        addTest("repeatSos", morseTypesPkg::CMD_SOS, morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DASH, morseTypesPkg::SYM_DOT, 2);
        addTest("repeatPrioSss", morseTypesPkg::morseCmd'(4'b1010), morseTypesPkg::SYM_DOT,
                morseTypesPkg::SYM_DOT, morseTypesPkg::SYM_DOT, 2);

        // outputs stay quiet during reset and right after it
        startErr = errCount;
        repeat (5) begin
            @(negedge CLK);
            checkSound("reset", '0, snd);
            if (cmdDone !== 1'b0) reportFault("cmdDone high during reset");
        end
        RSTn = 1'b1;
        repeat (3) begin
            @(negedge CLK);
            checkSound("reset", '0, snd);
            if (cmdDone !== 1'b0) reportFault("cmdDone high after reset");
        end
        monitorOn = 1'b1;
        if (errCount == startErr) passCount++;
        else failCount++;
        $display("%s reset", (errCount == startErr) ? "PASS" : "FAIL");

        for (int i = 0; i < rows.size(); i++) begin
            row      = rows[i];
            curRow   = row;
            curName  = names[i];
            reps     = int'(row.repeats);
            startErr = errCount;
            seen.delete();
            doneCount = 0;
            cmd       = row.cmd;  // held until the last cmdDone
            waited    = 0;
            while (doneCount < reps && waited < WORD_LIMIT * reps) begin
                @(negedge CLK);
                waited++;
            end
            if (doneCount < reps) reportFault($sformatf("no cmdDone within %0d cycles", waited));
            cmd = morseTypesPkg::CMD_NONE;
            repeat (5) @(negedge CLK);

            if (doneCount != reps) reportFault($sformatf("%0d cmdDone pulses", doneCount));
            if (seen.size() != 3 * reps) reportFault($sformatf("%0d marks seen", seen.size()));
            for (int k = 0; k < 3 * reps; k++) begin
                checkSymbol($sformatf("%s symbol %0d", curName, k), rowSymbol(row, k % 3),
                            (k < seen.size()) ? seen[k] : morseTypesPkg::SYM_NONE);
            end
            if (errCount == startErr) passCount++;
            else failCount++;
            $display("%s %s", (errCount == startErr) ? "PASS" : "FAIL", curName);
        end

        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
        if (errCount == 0 && failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
morseTypesPkg.sv
morseTimingPkg.sv
cmdControl.sv
symbolTimer.sv
toneGenerator.sv
morseTop.sv
tbClock.sv
morseTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f flist.f --top-module morseTb -o morseSim

./obj_dir/morseSim > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
